// File: hw/icache_pkg.sv
// icache geometry is fixed here: 8 KiB direct mapped, 32-byte lines, 16-bit bus, read only
`default_nettype none

package icache_pkg;

   // cache geometry
   localparam int NUM_SETS   = 256;
   localparam int LINE_BEATS = 16;
   localparam int LINE_BYTES = 32;

   // field positions in the byte address
   // tag 31..13, set 12..5, halfword offset 4..1
   localparam int TAG_LSB = 13;
   localparam int SET_LSB = 5;
   localparam int OFF_LSB = 1;

   typedef logic [31:0] addr_t;
   typedef logic [18:0] tag_t;
   typedef logic [7:0]  set_t;
   // halfword offset in a line, also the refill beat number
   typedef logic [3:0]  beat_t;
   typedef logic [15:0] half_t;
   typedef logic [31:0] word_t;

   // one cache line as seen by the tag store
   typedef struct packed {
      set_t set;
      tag_t tag;
   } line_ref_t;

   // fetch result: instruction halfword then 32-bit immediate
   typedef struct packed {
      half_t inst;
      word_t imm;
   } fetch_win_t;

   // wishbone style read request
   typedef struct packed {
      logic  cyc;
      logic  stb;
      addr_t adr;
   } bus_req_t;

   typedef enum logic [1:0] {
      FILL_IDLE   = 2'd0,
      FILL_FIRST  = 2'd1,
      FILL_SECOND = 2'd2,
      FILL_DONE   = 2'd3
   } fill_state_e;

endpackage

`default_nettype wire

// File: hw/icache_tag_store.sv
// tags have no reset, only the valid bits clear; two lookups are combinational, one write port
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store (
   input  logic                  clk_i,
   input  logic                  rst_i,
   // lookups for the line at the address and the line after it
   input  icache_pkg::line_ref_t look_first_i,
   input  icache_pkg::line_ref_t look_second_i,
   // written on the last beat of a refill
   input  logic                  tag_we_i,
   input  icache_pkg::line_ref_t tag_wr_i,
   output logic                  hit_first_o,
   output logic                  hit_second_o
);

   import icache_pkg::*;

   // one valid bit per set
   logic [NUM_SETS-1:0] valid_q;
   // stored tag per set
   tag_t                tags_q [NUM_SETS];

   // valid bits are control state and clear on reset
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         valid_q <= '0;
      end
      else if (tag_we_i)
      begin
         valid_q[tag_wr_i.set] <= 1'b1;
      end
   end

   // tag array has no reset, the valid bit covers it
   always_ff @(posedge clk_i)
   begin
      if (tag_we_i)
      begin
         tags_q[tag_wr_i.set] <= tag_wr_i.tag;
      end
   end

   // hit needs a valid entry with a matching tag
   assign hit_first_o  = valid_q[look_first_i.set] &&
                         (tags_q[look_first_i.set] == look_first_i.tag);
   // the second lookup is used only when the window crosses a line
   assign hit_second_o = valid_q[look_second_i.set] &&
                         (tags_q[look_second_i.set] == look_second_i.tag);

endmodule

`default_nettype wire

// File: hw/icache_line_store.sv
// data array has no reset; window read is combinational and wraps from set 255 to set 0
`timescale 1ns/1ps
`default_nettype none

module icache_line_store (
   input  logic                   clk_i,
   // one halfword per bus acknowledge
   input  logic                   we_i,
   input  icache_pkg::set_t       wr_set_i,
   input  icache_pkg::beat_t      wr_beat_i,
   input  icache_pkg::half_t      wr_data_i,
   // window read at set and halfword offset
   input  icache_pkg::set_t       rd_set_i,
   input  icache_pkg::beat_t      rd_off_i,
   output icache_pkg::fetch_win_t win_o
);

   import icache_pkg::*;

   // flat halfword index is set times 16 plus beat
   typedef logic [$bits(set_t)+$bits(beat_t)-1:0] idx_t;

   half_t mem_q [NUM_SETS*LINE_BEATS];

   idx_t wr_idx;
   idx_t rd_idx0;
   idx_t rd_idx1;
   idx_t rd_idx2;

   assign wr_idx = {wr_set_i, wr_beat_i};

   always_ff @(posedge clk_i)
   begin
      if (we_i)
      begin
         mem_q[wr_idx] <= wr_data_i;
      end
   end

   // three consecutive halfwords
   // index width makes the sum wrap modulo 4096, so the top set runs into set 0
   assign rd_idx0 = {rd_set_i, rd_off_i};
   assign rd_idx1 = rd_idx0 + idx_t'(1);
   assign rd_idx2 = rd_idx0 + idx_t'(2);

   // immediate is the upper halfword first
   assign win_o.inst = mem_q[rd_idx0];
   assign win_o.imm  = {mem_q[rd_idx1], mem_q[rd_idx2]};

endmodule

`default_nettype wire

// File: hw/icache_beat_counter.sv
// counts acks within one line; wraps after the 16th beat so each line starts at beat 0
`timescale 1ns/1ps
`default_nettype none

module icache_beat_counter (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              adv_i,
   output icache_pkg::beat_t beat_o,
   output logic              last_o
);

   import icache_pkg::*;

   beat_t beat_q;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         beat_q <= '0;
      end
      else if (adv_i)
      begin
         // natural wrap from 15 to 0
         beat_q <= beat_q + beat_t'(1);
      end
   end

   assign beat_o = beat_q;
   // an ack in this state finishes the line
   assign last_o = (beat_q == beat_t'(LINE_BEATS - 1));

endmodule

`default_nettype wire

// File: hw/icache_fill_ctrl.sv
// one beat outstanding at a time; fetch address must stay steady until ready, no bus errors
`timescale 1ns/1ps
`default_nettype none

module icache_fill_ctrl (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  fetch_valid_i,
   // line at the address and the line after it
   input  icache_pkg::line_ref_t first_i,
   input  icache_pkg::line_ref_t second_i,
   input  logic                  hit_first_i,
   input  logic                  hit_second_i,
   input  logic                  need_second_i,
   // bus acknowledge and beat counter
   input  logic                  bus_ack_i,
   input  logic                  last_beat_i,
   input  icache_pkg::beat_t     beat_i,
   output icache_pkg::bus_req_t  bus_o,
   // refill writes
   output logic                  fill_we_o,
   output icache_pkg::set_t      fill_set_o,
   output logic                  tag_we_o,
   output icache_pkg::line_ref_t tag_wr_o
);

   import icache_pkg::*;

   fill_state_e state_q;
   // line being refilled
   line_ref_t   cur_q;

   logic miss_first;
   logic miss_second;
   logic active;
   logic line_done;

   assign miss_first  = fetch_valid_i && !hit_first_i;
   // second line matters only when the window crosses into it
   assign miss_second = fetch_valid_i && need_second_i && !hit_second_i;
   assign active      = (state_q == FILL_FIRST) || (state_q == FILL_SECOND);
   // 16th ack of the current line
   assign line_done   = active && bus_ack_i && last_beat_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q <= FILL_IDLE;
      end
      else
      begin
         case (state_q)
            FILL_IDLE:
            begin
               if (miss_first)
                  state_q <= FILL_FIRST;
               else if (miss_second)
                  state_q <= FILL_SECOND;
            end
            FILL_FIRST:
            begin
               // go straight on to the next line, stb stays high
               if (line_done)
                  state_q <= miss_second ? FILL_SECOND : FILL_DONE;
            end
            FILL_SECOND:
            begin
               if (line_done)
                  state_q <= FILL_DONE;
            end
            FILL_DONE:
            begin
               // one quiet cycle with cyc and stb low
               state_q <= FILL_IDLE;
            end
         endcase
      end
   end

   // line reference latched when a refill starts
   always_ff @(posedge clk_i)
   begin
      if (state_q == FILL_IDLE)
         cur_q <= miss_first ? first_i : second_i;
      else if ((state_q == FILL_FIRST) && line_done)
         cur_q <= second_i;
   end

   // cyc and stb follow the state, so they rise one clock after the miss
   assign bus_o.cyc = active;
   assign bus_o.stb = active;
   // beat count steps the address by 2 after every ack
   assign bus_o.adr = {cur_q.tag, cur_q.set, beat_i, 1'b0};

   assign fill_we_o  = active && bus_ack_i;
   assign fill_set_o = cur_q.set;
   assign tag_we_o   = line_done;
   assign tag_wr_o   = cur_q;

endmodule

`default_nettype wire

// File: hw/icache_top.sv
// read-only icache; fetch_ready_o is combinational and the window is valid only with ready high
`timescale 1ns/1ps
`default_nettype none

module icache_top (
   input  logic                   clk_i,
   input  logic                   rst_i,
   // fetch side, valid/ready
   input  logic                   fetch_valid_i,
   input  icache_pkg::addr_t      fetch_addr_i,
   output logic                   fetch_ready_o,
   output icache_pkg::fetch_win_t fetch_win_o,
   // memory bus side
   output icache_pkg::bus_req_t   bus_o,
   input  icache_pkg::half_t      bus_dat_i,
   input  logic                   bus_ack_i
);

   import icache_pkg::*;

   addr_t     next_addr;
   beat_t     off;
   line_ref_t first_ref;
   line_ref_t second_ref;
   logic      need_second;
   logic      hit_first;
   logic      hit_second;
   logic      fill_we;
   set_t      fill_set;
   logic      tag_we;
   line_ref_t tag_wr;
   beat_t     beat;
   logic      last_beat;

   // field split of the fetch address
   assign off       = fetch_addr_i[OFF_LSB +: $bits(beat_t)];
   assign first_ref = '{set: fetch_addr_i[SET_LSB +: $bits(set_t)],
                        tag: fetch_addr_i[TAG_LSB +: $bits(tag_t)]};

   // next line by address arithmetic, so set 255 carries into the tag
   assign next_addr  = fetch_addr_i + addr_t'(LINE_BYTES);
   assign second_ref = '{set: next_addr[SET_LSB +: $bits(set_t)],
                         tag: next_addr[TAG_LSB +: $bits(tag_t)]};

   // window of three halfwords crosses the line from offset 14 up
   assign need_second = (off >= beat_t'(LINE_BEATS - 2));

   assign fetch_ready_o = fetch_valid_i && hit_first && (!need_second || hit_second);

   icache_tag_store u_tags (
      .clk_i, .rst_i, .look_first_i(first_ref), .look_second_i(second_ref),
      .tag_we_i(tag_we), .tag_wr_i(tag_wr),
      .hit_first_o(hit_first), .hit_second_o(hit_second));

   icache_line_store u_lines (
      .clk_i, .we_i(fill_we), .wr_set_i(fill_set), .wr_beat_i(beat),
      .wr_data_i(bus_dat_i), .rd_set_i(first_ref.set), .rd_off_i(off),
      .win_o(fetch_win_o));

   // counter advances on every refill ack
   icache_beat_counter u_beats (
      .clk_i, .rst_i, .adv_i(fill_we), .beat_o(beat), .last_o(last_beat));

   icache_fill_ctrl u_fill (
      .clk_i, .rst_i, .fetch_valid_i, .first_i(first_ref), .second_i(second_ref),
      .hit_first_i(hit_first), .hit_second_i(hit_second), .need_second_i(need_second),
      .bus_ack_i, .last_beat_i(last_beat), .beat_i(beat), .bus_o,
      .fill_we_o(fill_we), .fill_set_o(fill_set), .tag_we_o(tag_we), .tag_wr_o(tag_wr));

endmodule

`default_nettype wire

// File: sim/icache_props.sv
// bound into icache_top; checks bus request rules and a quiet bus until the first fetch
`timescale 1ns/1ps
`default_nettype none

module icache_props (
   input logic                 clk_i,
   input logic                 rst_i,
   input logic                 fetch_valid_i,
   input icache_pkg::bus_req_t bus_o,
   input logic                 bus_ack_i
);

   // set once a fetch has been requested since reset
   logic seen_valid_q;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         seen_valid_q <= 1'b0;
      else if (fetch_valid_i)
         seen_valid_q <= 1'b1;
   end

   // a cycle closes only after its last strobe was acknowledged
   a_cyc_end: assert property (@(posedge clk_i) disable iff (rst_i)
      $fell(bus_o.cyc) |-> $past(bus_o.stb && bus_ack_i))
      else $error("bus cycle ended without an acknowledged strobe");

   // request held with a steady address until ack
   a_adr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (bus_o.stb && !bus_ack_i) |=> (bus_o.stb && $stable(bus_o.adr)))
      else $error("bus request changed before ack");

   a_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
      !seen_valid_q |-> !bus_o.cyc)
      else $error("bus cycle started before any fetch");

endmodule

bind icache_top icache_props u_props (.clk_i, .rst_i, .fetch_valid_i, .bus_o, .bus_ack_i);

`default_nettype wire

// File: sim/icache_tb.sv
// reads sim/icache_patterns.txt relative to the project root; memory answers after 0 to 3 idle cycles
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

   import icache_pkg::*;

   localparam int MAX_PATS = 32;
   // wait limit per fetch in clock cycles
   localparam int TIMEOUT  = 500;

   logic       clk_i = 1'b0;
   logic       rst_i;
   logic       fetch_valid_i;
   addr_t      fetch_addr_i;
   logic       fetch_ready_o;
   fetch_win_t fetch_win_o;
   bus_req_t   bus_o;
   half_t      bus_dat_i;
   logic       bus_ack_i;

   // each pattern is three words for test code, address and expected acks
   logic [31:0] pats [MAX_PATS*3];
   int          seed      = 20;
   // idle cycles left before the model acks the current beat or -1 with no beat open
   int          idle_left = -1;
   int          num_pats;

   // lines the cache should hold after the fetches so far
   logic [NUM_SETS-1:0] res_valid;
   tag_t                res_tag [NUM_SETS];

   icache_top dut (.*);

   always #4 clk_i = ~clk_i;

   // memory content is a scramble of address bits 16..1
   function automatic half_t mem_half(input addr_t a);
      return a[16:1] ^ 16'hA5C3;
   endfunction

   // direct mapped with the set in address bits 12..5 and the tag in bits 31..13
   function automatic logic line_resident(input addr_t a);
      return res_valid[a[12:5]] && (res_tag[a[12:5]] == a[31:13]);
   endfunction

   task automatic mark_resident(input addr_t a);
      res_valid[a[12:5]] = 1'b1;
      res_tag[a[12:5]]   = a[31:13];
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "testbench stopped at the first error");
   endtask

   task automatic check_win(input int code, input fetch_win_t exp, input fetch_win_t act);
      if (act !== exp)
         abort_run($sformatf("FAIL test %0h window: expected %h, actual %h", code, exp, act));
   endtask

   task automatic check_count(input int code, input string what, input int exp, input int act);
      if (act != exp)
         abort_run($sformatf("FAIL test %0h %s: expected %0d, actual %0d", code, what, exp, act));
   endtask

   task automatic check_addr(input int code, input addr_t exp, input addr_t act);
      if (act !== exp)
         abort_run($sformatf("FAIL test %0h bus address: expected %h, actual %h", code, exp, act));
   endtask

   task automatic apply_reset();
      @(posedge clk_i);
      #1;
      rst_i = 1'b1;
      // reset empties the cache
      res_valid = '0;
      repeat (8) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
   endtask

   // memory model answers one beat at a time after random idle cycles
   always @(posedge clk_i)
   begin
      #1;
      if (bus_o.stb)
      begin
         // a new beat draws its delay
         if (idle_left < 0)
            idle_left = $random(seed) & 3;
         if (idle_left == 0)
         begin
            bus_ack_i = 1'b1;
            bus_dat_i = mem_half(bus_o.adr);
            idle_left = -1;
         end
         else
         begin
            bus_ack_i = 1'b0;
            idle_left = idle_left - 1;
         end
      end
      else
      begin
         bus_ack_i = 1'b0;
         idle_left = -1;
      end
   end

   task automatic run_fetch(input int code, input addr_t a, input int exp_acks);
      int         acks;
      int         cycles;
      logic       done;
      logic       first_res;
      addr_t      prev;
      addr_t      exp_adr;
      addr_t      base;
      addr_t      nxt_base;
      fetch_win_t exp_win;
      acks      = 0;
      cycles    = 0;
      done      = 1'b0;
      prev      = '0;
      base      = {a[31:5], 5'b0};
      nxt_base  = base + addr_t'(LINE_BYTES);
      first_res = line_resident(a);
      @(posedge clk_i);
      #1;
      fetch_valid_i = 1'b1;
      fetch_addr_i  = a;
      // sample at the falling edge where outputs have settled
      while (!done)
      begin
         @(negedge clk_i);
         if (bus_o.stb && bus_ack_i)
         begin
            // refill starts with the missing line and a crossing takes the next line second
            if (acks == 0)
               exp_adr = first_res ? nxt_base : base;
            else if (acks == LINE_BEATS)
               exp_adr = nxt_base;
            else
               exp_adr = prev + addr_t'(2);
            check_addr(code, exp_adr, bus_o.adr);
            prev = bus_o.adr;
            acks++;
         end
         if (fetch_ready_o)
            done = 1'b1;
         else
         begin
            cycles++;
            if (cycles >= TIMEOUT)
               abort_run($sformatf("test %0h: fetch at %h never became ready", code, a));
         end
      end
      check_count(code, "acks", exp_acks, acks);
      // a hit is ready in the cycle valid rises
      if (exp_acks == 0)
         check_count(code, "wait cycles", 0, cycles);
      exp_win.inst = mem_half(a);
      exp_win.imm  = {mem_half(a + addr_t'(2)), mem_half(a + addr_t'(4))};
      check_win(code, exp_win, fetch_win_o);
      mark_resident(a);
      // window from byte offset 28 up reaches into the next line
      if (a[4:0] >= 5'd28)
         mark_resident(nxt_base);
      // fetch completes on this edge
      @(posedge clk_i);
      #1;
      fetch_valid_i = 1'b0;
   endtask

   initial
   begin
      int i;
      rst_i         = 1'b1;
      fetch_valid_i = 1'b0;
      fetch_addr_i  = '0;
      bus_dat_i     = '0;
      bus_ack_i     = 1'b0;
      num_pats      = 0;
      // all ones marks the end of the list
      for (i = 0; i < MAX_PATS*3; i++)
         pats[i] = '1;
      $readmemh("sim/icache_patterns.txt", pats);
      apply_reset();
      while ((num_pats < MAX_PATS) && (pats[num_pats*3] != '1))
      begin
         // bit 8 of the code asks for a reset first
         if (pats[num_pats*3][8])
            apply_reset();
         run_fetch(int'(pats[num_pats*3]), pats[num_pats*3+1], int'(pats[num_pats*3+2]));
         num_pats++;
      end
      if (num_pats == 0)
         abort_run("no patterns could be read from the pattern file");
      else
      begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: sim/icache_patterns.txt
// columns: test code (hex, bit 8 = reset first), byte address, expected acks (hex)
// 10 = one line refilled, 20 = two lines
011 00001000 10 // cold miss, aligned
021 00001000 00 // repeat hits
022 0000100a 00 // other offset, same line
023 0000101a 00 // offset 26 stays in the line
031 0000205c 20 // offset 28, both lines cold
032 0000101e 10 // offset 30, only first line resident
033 0000101c 00 // both lines now resident
034 00000ffc 10 // offset 28, only second line resident
041 00005ffe 20 // set 255 offset 30, next line is set 0 tag plus one
042 00006000 00 // next line hits
043 00006002 00
051 00003000 10 // same set, other tag evicts
052 00001000 10 // original refetched
053 0000100a 00
161 00001000 10 // after a second reset
062 00001000 00
063 00005ffe 20
064 00006000 00

// File: verilog.f
hw/icache_pkg.sv
hw/icache_tag_store.sv
hw/icache_line_store.sv
hw/icache_beat_counter.sv
hw/icache_fill_ctrl.sv
hw/icache_top.sv
sim/icache_props.sv
sim/icache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module icache_tb -o icache_sim
out=$(./obj_dir/icache_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qF '** PASS **'; then
   exit 0
fi
echo "simulation did not pass"
exit 1
